//--- Makefile
# Verilator build and run for the SDRAM front end testbench

SIM        ?= verilator
TOP        ?= tb_sdram_frontend
FILELIST   ?= sources.f
SIM_FLAGS  ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
PASS_TEXT  := Test OK

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

# pass only if the pass message shows up in the output
run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

//--- include/sdram_defines.svh
// SDRAM front end sizing
// address, row field, bank count and idle counter widths
// shared by the packages and every front end module

`ifndef SDRAM_DEFINES_SVH
`define SDRAM_DEFINES_SVH

// client word address width
`define SDRAM_AW      22
// row field width and its low bit in the address
`define SDRAM_ROW_W   12
`define SDRAM_ROW_LSB 10
// banks, one client each
`define SDRAM_BANKS   4
// idle close counter width
`define SDRAM_IDLE_W  8

`endif

//--- sources.f
+incdir+include
verilog/sdram_cmd_pkg.sv
verilog/sdram_cfg_pkg.sv
verilog/sdram_req_latch.sv
verilog/sdram_row_track.sv
verilog/sdram_bank_sched.sv
verilog/sdram_bank_cfg.sv
verilog/sdram_frontend.sv
testbench/sdram_checker.sv
testbench/tb_sdram_frontend.sv

//--- testbench/sdram_checker.sv
// SDRAM front end checker
// keeps its own open-row model from the issued commands and checks
// each command, done pulse, readback and the idle close timing

`default_nettype none

`include "sdram_defines.svh"

module sdram_checker (
    input  wire logic                                   clk,
    input  wire logic                                   rst,
    input  sdram_cmd_pkg::bank_req_t [`SDRAM_BANKS-1:0] req,
    input  wire logic                                   prog_en,
    input  wire logic                                   prog_rd,
    input  wire logic                                   prog_wr,
    input  sdram_cmd_pkg::sdram_cmd_t                   cmd,
    input  wire logic [`SDRAM_BANKS-1:0]                done,
    input  wire logic [7:0]                             cfg_rdata,
    input  int                                          test_id,
    input  wire logic                                   exp_auto_pre,
    input  wire logic [`SDRAM_IDLE_W-1:0]               exp_idle,
    input  wire logic                                   rd_check,
    input  wire logic [7:0]                             exp_rdata,
    output int                                          err_count
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [`SDRAM_BANKS-1:0]                   m_open;
    logic [`SDRAM_BANKS-1:0][`SDRAM_ROW_W-1:0] m_row;
    logic [`SDRAM_BANKS-1:0]                   served;
    int                                        quiet;
    int                                        prev_id;

    function automatic string test_name(input int id);
        case (id)
            1: return "reg_readback";
            2: return "row_hit_miss";
            3: return "fair_arbitration";
            4: return "auto_precharge";
            5: return "idle_close";
            default: return "startup";
        endcase
    endfunction

    task automatic value_err(input string what, input logic [31:0] exp, input logic [31:0] act);
        err_count++;
        $display("Error %s: %s expected %0h actual %0h", test_name(test_id), what, exp, act);
    endtask

    task automatic rule_err(input string what);
        err_count++;
        $display("%s: %s at %0t", test_name(test_id), what, $time);
    endtask

    always @(posedge clk) begin
        logic [1:0]                b;
        logic                      has;
        logic                      noreq;
        logic [`SDRAM_ROW_W-1:0]   rrow;
        logic [`SDRAM_BANKS-1:0]   exp_done;
        logic [1:0]                lowest;
        int                        k;
        if (rst) begin
            m_open    = '0;
            m_row     = '0;
            served    = '0;
            quiet     = 0;
            prev_id   = 0;
            err_count = 0;
        end else begin
            if (test_id != prev_id) begin
                served  = '0;
                prev_id = test_id;
            end
            b    = cmd.bank;
            has  = req[b].rd | req[b].wr;
            rrow = req[b].addr[`SDRAM_ROW_LSB +: `SDRAM_ROW_W];
            // quiet cycles before this one
            noreq = ~(prog_en & (prog_rd | prog_wr));
            for (int i = 0; i < `SDRAM_BANKS; i++) begin
                if (req[i].rd || req[i].wr) begin
                    noreq = 1'b0;
                end
            end
            k     = quiet;
            quiet = noreq ? quiet + 1 : 0;
            lowest = 2'd0;
            for (int i = `SDRAM_BANKS - 1; i >= 0; i--) begin
                if (m_open[i]) begin
                    lowest = 2'(i);
                end
            end
            if (rd_check && cfg_rdata != exp_rdata) begin
                value_err("cfg readback", 32'(exp_rdata), 32'(cfg_rdata));
            end
            // done goes only with an access to that bank
            exp_done = '0;
            if (cmd.code == sdram_cmd_pkg::RD || cmd.code == sdram_cmd_pkg::WR) begin
                exp_done[b] = 1'b1;
            end
            if (done != exp_done) begin
                value_err("done", 32'(exp_done), 32'(done));
            end
            if (test_id == 1 && cmd.code != sdram_cmd_pkg::NOP) begin
                value_err("cmd code", 32'(sdram_cmd_pkg::NOP), 32'(cmd.code));
            end
            if (exp_idle != 0 && k >= int'(exp_idle) + `SDRAM_BANKS && m_open != '0) begin
                rule_err("banks still open long after the idle limit");
            end
            case (cmd.code)
                sdram_cmd_pkg::ACT: begin
                    if (m_open[b]) begin
                        rule_err("ACT issued to a bank that is already open");
                    end
                    if (!has) begin
                        rule_err("ACT issued to a bank with no request");
                    end else if (cmd.row != rrow) begin
                        value_err("ACT row", 32'(rrow), 32'(cmd.row));
                    end
                    m_open[b] = 1'b1;
                    m_row[b]  = cmd.row;
                end
                sdram_cmd_pkg::PRE: begin
                    if (!m_open[b]) begin
                        rule_err("PRE issued to a closed bank");
                    end
                    if (has) begin
                        if (m_row[b] == rrow) begin
                            rule_err("PRE issued although the requested row is open");
                        end
                    end else begin
                        // idle close
                        if (!noreq || exp_idle == 0 || k < int'(exp_idle)) begin
                            rule_err("idle PRE issued before the idle limit");
                        end
                        if (b != lowest) begin
                            value_err("idle PRE bank", 32'(lowest), 32'(b));
                        end
                    end
                    m_open[b] = 1'b0;
                end
                sdram_cmd_pkg::RD, sdram_cmd_pkg::WR: begin
                    if (!has) begin
                        rule_err("access issued to a bank with no request");
                    end else begin
                        if (cmd.code != (req[b].wr ? sdram_cmd_pkg::WR : sdram_cmd_pkg::RD)) begin
                            value_err("access code", 32'(req[b].wr ? 4 : 3), 32'(cmd.code));
                        end
                        if (!m_open[b]) begin
                            rule_err("access issued to a closed bank");
                        end else if (m_row[b] != rrow) begin
                            value_err("open row", 32'(rrow), 32'(m_row[b]));
                        end
                        if (cmd.row != rrow) begin
                            value_err("access row", 32'(rrow), 32'(cmd.row));
                        end
                        if (cmd.col != {exp_auto_pre, req[b].addr[`SDRAM_ROW_LSB-2:0]}) begin
                            value_err("column", 32'({exp_auto_pre, req[b].addr[8:0]}),
                                      32'(cmd.col));
                        end
                    end
                    // one done per bank per round
                    if (test_id == 3) begin
                        if (served[b]) begin
                            rule_err("bank served twice before every bank was served");
                        end
                        served[b] = 1'b1;
                        if (&served) begin
                            served = '0;
                        end
                    end
                    if (cmd.col[`SDRAM_ROW_LSB-1]) begin
                        m_open[b] = 1'b0;
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_sdram_frontend.sv
// SDRAM front end testbench
// seeded random clients on four banks, configuration writes,
// prog hold-off and a watchdog, checker watches the DUT

`default_nettype none

`include "sdram_defines.svh"

module tb_sdram_frontend;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 8;
    localparam int N_HITMISS  = 10;
    localparam int N_FAIR     = 12;
    localparam int N_AUTO     = 6;
    localparam int N_IDLE     = 2;
    localparam int IDLE_LIM   = 6;
    // requests over all tests, 4 cycles each, plus config and idle waits
    localparam int REQ_TOTAL  = `SDRAM_BANKS * (N_HITMISS + N_FAIR + N_AUTO + N_IDLE);
    localparam int FIXED_CYC  = 200;
    localparam int WATCHDOG   = (REQ_TOTAL * 4 + FIXED_CYC) * CLK_PERIOD;

    logic                                       clk;
    logic                                       rst;
    sdram_cmd_pkg::bank_req_t [`SDRAM_BANKS-1:0] req = '0;
    logic                                       prog_en;
    logic                                       prog_rd;
    logic                                       prog_wr;
    logic                                       cfg_wr;
    logic                                       cfg_addr;
    logic [7:0]                                 cfg_wdata;
    logic [7:0]                                 cfg_rdata;
    sdram_cmd_pkg::sdram_cmd_t                  cmd;
    logic [`SDRAM_BANKS-1:0]                    done;

    // shared with the checker
    int                         test_id;
    logic                       exp_auto_pre;
    logic [`SDRAM_IDLE_W-1:0]   exp_idle;
    logic                       rd_check;
    logic [7:0]                 exp_rdata;
    int                         err_count;

    // client bookkeeping
    int                         seed = 70758;
    int                         quota [`SDRAM_BANKS];
    int                         issued [`SDRAM_BANKS];
    logic [`SDRAM_BANKS-1:0]    busy;
    logic                       dense;
    int                         tests_run;
    int                         tests_failed;

    sdram_frontend #(
        .LATCH(0)
    ) uut (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .prog_en   (prog_en),
        .prog_rd   (prog_rd),
        .prog_wr   (prog_wr),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .cmd       (cmd),
        .done      (done)
    );

    sdram_checker u_check (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .prog_en      (prog_en),
        .prog_rd      (prog_rd),
        .prog_wr      (prog_wr),
        .cmd          (cmd),
        .done         (done),
        .cfg_rdata    (cfg_rdata),
        .test_id      (test_id),
        .exp_auto_pre (exp_auto_pre),
        .exp_idle     (exp_idle),
        .rd_check     (rd_check),
        .exp_rdata    (exp_rdata),
        .err_count    (err_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // clients hold rd/wr and address until their done pulse
    always @(posedge clk) begin
        int r;
        logic [`SDRAM_ROW_W-1:0] row;
        for (int b = 0; b < `SDRAM_BANKS; b++) begin
            if (rst) begin
                req[b]    <= '0;
                busy[b]   <= 1'b0;
                issued[b] <= 0;
            end else if (busy[b]) begin
                if (done[b]) begin
                    req[b]  <= '0;
                    busy[b] <= 1'b0;
                end
            end else if (issued[b] < quota[b]) begin
                r = $random(seed);
                // few rows per bank so hits and misses both occur
                row = `SDRAM_ROW_W'(r[1:0]);
                if (dense || r[31]) begin
                    req[b].addr <= {row, r[13:4]};
                    req[b].wr   <= r[2];
                    req[b].rd   <= ~r[2];
                    busy[b]     <= 1'b1;
                    issued[b]   <= issued[b] + 1;
                end
            end
        end
    end

    task automatic cfg_write(input logic addr, input logic [7:0] data);
        @(posedge clk);
        cfg_wr    <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge clk);
        cfg_wr <= 1'b0;
        // model follows the register at the same edge
        if (addr == sdram_cfg_pkg::REG_POLICY) begin
            exp_auto_pre <= data[0];
        end else begin
            exp_idle <= data[`SDRAM_IDLE_W-1:0];
        end
    endtask

    task automatic cfg_readback(input logic addr, input logic [7:0] expected);
        @(posedge clk);
        cfg_addr  <= addr;
        rd_check  <= 1'b1;
        exp_rdata <= expected;
        @(posedge clk);
        rd_check <= 1'b0;
    endtask

    // quotas change between edges, clients pick them up on the next one
    task automatic add_requests(input int n);
        @(negedge clk);
        for (int b = 0; b < `SDRAM_BANKS; b++) begin
            quota[b] = quota[b] + n;
        end
    endtask

    task automatic wait_clients();
        logic all_done;
        all_done = 1'b0;
        while (!all_done) begin
            @(posedge clk);
            all_done = (busy == '0);
            for (int b = 0; b < `SDRAM_BANKS; b++) begin
                if (issued[b] != quota[b]) begin
                    all_done = 1'b0;
                end
            end
        end
        @(posedge clk);
    endtask

    // test number and error baseline move between clock edges
    task automatic start_test(input int id, output int errs_before);
        @(negedge clk);
        test_id     = id;
        errs_before = err_count;
    endtask

    task automatic end_test(input string name, input int errs_before);
        @(negedge clk);
        tests_run++;
        if (err_count != errs_before) begin
            tests_failed++;
            $display("%s: failed, %0d errors", name, err_count - errs_before);
        end else begin
            $display("%s: passed", name);
        end
    endtask

    initial begin
        #(WATCHDOG);
        $display("watchdog expired after %0d ns, clients never finished", WATCHDOG);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        int errs;
        rst          = 1'b1;
        prog_en      = 1'b0;
        prog_rd      = 1'b0;
        prog_wr      = 1'b0;
        cfg_wr       = 1'b0;
        cfg_addr     = 1'b0;
        cfg_wdata    = 8'd0;
        test_id      = 0;
        exp_auto_pre = 1'b0;
        exp_idle     = '0;
        rd_check     = 1'b0;
        exp_rdata    = 8'd0;
        dense        = 1'b0;
        tests_run    = 0;
        tests_failed = 0;
        for (int b = 0; b < `SDRAM_BANKS; b++) begin
            quota[b] = 0;
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        start_test(1, errs);
        cfg_write(sdram_cfg_pkg::REG_POLICY, 8'h01);
        cfg_readback(sdram_cfg_pkg::REG_POLICY, 8'h01);
        cfg_write(sdram_cfg_pkg::REG_IDLE, 8'hA5);
        cfg_readback(sdram_cfg_pkg::REG_IDLE, 8'hA5);
        cfg_write(sdram_cfg_pkg::REG_POLICY, 8'h00);
        cfg_write(sdram_cfg_pkg::REG_IDLE, 8'h00);
        cfg_readback(sdram_cfg_pkg::REG_POLICY, 8'h00);
        cfg_readback(sdram_cfg_pkg::REG_IDLE, 8'h00);
        end_test("reg_readback", errs);

        start_test(2, errs);
        add_requests(N_HITMISS);
        wait_clients();
        end_test("row_hit_miss", errs);

        // no gaps, every bank keeps asking
        start_test(3, errs);
        dense = 1'b1;
        add_requests(N_FAIR);
        wait_clients();
        dense = 1'b0;
        end_test("fair_arbitration", errs);

        start_test(4, errs);
        cfg_write(sdram_cfg_pkg::REG_POLICY, 8'h01);
        add_requests(N_AUTO);
        wait_clients();
        cfg_write(sdram_cfg_pkg::REG_POLICY, 8'h00);
        end_test("auto_precharge", errs);

        // prog access keeps the banks open, then quiet lets them close
        start_test(5, errs);
        @(posedge clk);
        prog_en <= 1'b1;
        prog_rd <= 1'b1;
        cfg_write(sdram_cfg_pkg::REG_IDLE, 8'(IDLE_LIM));
        add_requests(N_IDLE);
        wait_clients();
        repeat (20) @(posedge clk);
        prog_en <= 1'b0;
        prog_rd <= 1'b0;
        repeat (IDLE_LIM + 12) @(posedge clk);
        cfg_write(sdram_cfg_pkg::REG_IDLE, 8'h00);
        end_test("idle_close", errs);

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/sdram_bank_cfg.sv
// SDRAM configuration registers
// auto-precharge policy and idle limit, written by strobe,
// read back combinationally and handed on as one struct

`default_nettype none

`include "sdram_defines.svh"

module sdram_bank_cfg (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          cfg_wr,
    input  wire logic          cfg_addr,
    input  wire logic [7:0]    cfg_wdata,
    output logic [7:0]         cfg_rdata,
    output sdram_cfg_pkg::cfg_t cfg
);

    // both registers off after reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg <= '0;
        end else if (cfg_wr) begin
            case (cfg_addr)
                sdram_cfg_pkg::REG_POLICY: begin
                    // bit 0 only
                    cfg.auto_pre <= cfg_wdata[0];
                end
                sdram_cfg_pkg::REG_IDLE: begin
                    cfg.idle_limit <= cfg_wdata[`SDRAM_IDLE_W-1:0];
                end
                default: begin
                end
            endcase
        end
    end

    // readback of the addressed register
    always_comb begin
        if (cfg_addr == sdram_cfg_pkg::REG_IDLE) begin
            cfg_rdata = 8'(cfg.idle_limit);
        end else begin
            cfg_rdata = {7'd0, cfg.auto_pre};
        end
    end

endmodule

`default_nettype wire

//--- verilog/sdram_bank_sched.sv
// SDRAM bank scheduler
// round-robin choice among requesting banks, one command per cycle
// PRE and ACT as needed, then RD or WR with a done pulse
// idle close requests fill otherwise empty cycles

`default_nettype none

`include "sdram_defines.svh"

module sdram_bank_sched (
    input  wire logic                                   clk,
    input  wire logic                                   rst,
    input  sdram_cmd_pkg::bank_req_t [`SDRAM_BANKS-1:0] req_l,
    input  wire logic [`SDRAM_BANKS-1:0]                match,
    input  wire logic [`SDRAM_BANKS-1:0]                open,
    input  sdram_cmd_pkg::idle_pre_t                    idle_pre,
    input  sdram_cfg_pkg::cfg_t                         cfg,
    output sdram_cmd_pkg::sdram_cmd_t                   cmd,
    output logic [`SDRAM_BANKS-1:0]                     done
);

    logic [1:0]              rr_ptr;
    logic [`SDRAM_BANKS-1:0] mask;
    logic [`SDRAM_BANKS-1:0] pending;
    logic                    found;
    logic [1:0]              win;

    // requests still waiting, minus a bank just served
    always_comb begin
        for (int b = 0; b < `SDRAM_BANKS; b++) begin
            pending[b] = (req_l[b].rd | req_l[b].wr) & ~mask[b];
        end
    end

    // search starts at the pointer and wraps
    always_comb begin
        logic [1:0] idx;
        found = 1'b0;
        win   = rr_ptr;
        for (int i = 0; i < `SDRAM_BANKS; i++) begin
            idx = rr_ptr + 2'(i);
            if (!found && pending[idx]) begin
                found = 1'b1;
                win   = idx;
            end
        end
    end

    // next step for the winner
    always_comb begin
        cmd  = '{code: sdram_cmd_pkg::NOP, bank: 2'd0, row: '0, col: '0};
        done = '0;
        if (found) begin
            cmd.bank = win;
            cmd.row  = req_l[win].addr[`SDRAM_ROW_LSB +: `SDRAM_ROW_W];
            if (!open[win]) begin
                // closed bank
                cmd.code = sdram_cmd_pkg::ACT;
            end else if (!match[win]) begin
                // other row open
                cmd.code = sdram_cmd_pkg::PRE;
            end else begin
                // row hit, access and finish
                cmd.code  = req_l[win].wr ? sdram_cmd_pkg::WR : sdram_cmd_pkg::RD;
                cmd.col   = {cfg.auto_pre, req_l[win].addr[`SDRAM_ROW_LSB-2:0]};
                done[win] = 1'b1;
            end
        end else if (idle_pre.valid) begin
            // free slot, close an idle bank
            cmd.code = sdram_cmd_pkg::PRE;
            cmd.bank = idle_pre.bank;
        end
    end

    // pointer moves only when a bank completes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rr_ptr <= '0;
            mask   <= '0;
        end else begin
            // stale request may linger one cycle after done
            mask <= done;
            if (|done) begin
                rr_ptr <= win + 2'd1;
            end
        end
    end

    // a lingering request never completes a second time right after done
    a_done_masked: assert property (@(posedge clk) disable iff (rst)
        |done |=> !(|(done & $past(done))));

endmodule

`default_nettype wire

//--- verilog/sdram_cfg_pkg.sv
// SDRAM configuration package
// register map of the configuration port and the decoded
// configuration that steers the row tracker and scheduler

`default_nettype none

`include "sdram_defines.svh"

package sdram_cfg_pkg;

    // 1-bit register map
    localparam logic REG_POLICY = 1'b0;
    localparam logic REG_IDLE   = 1'b1;

    typedef struct packed {
        // close the row with every RD/WR
        logic                     auto_pre;
        // idle cycles before closing rows, 0 disables
        logic [`SDRAM_IDLE_W-1:0] idle_limit;
    } cfg_t;

endpackage

`default_nettype wire

//--- verilog/sdram_cmd_pkg.sv
// SDRAM command package
// command codes, the issued command word, the per-bank client request
// and the idle close request from the row tracker

`default_nettype none

`include "sdram_defines.svh"

package sdram_cmd_pkg;

    typedef enum logic [2:0] {
        NOP = 3'd0,
        ACT = 3'd1,
        PRE = 3'd2,
        RD  = 3'd3,
        WR  = 3'd4
    } cmd_e;

    // one command per cycle, col top bit is auto-precharge
    typedef struct packed {
        cmd_e                      code;
        logic [1:0]                bank;
        logic [`SDRAM_ROW_W-1:0]   row;
        logic [`SDRAM_ROW_LSB-1:0] col;
    } sdram_cmd_t;

    // rd and wr are levels held until done
    typedef struct packed {
        logic [`SDRAM_AW-1:0] addr;
        logic                 rd;
        logic                 wr;
    } bank_req_t;

    // tracker asks to close one bank
    typedef struct packed {
        logic       valid;
        logic [1:0] bank;
    } idle_pre_t;

endpackage

`default_nettype wire

//--- verilog/sdram_frontend.sv
// SDRAM controller request front end
// latch, row tracker, bank scheduler and configuration registers
// for four banks with one level-driven client each

`default_nettype none

`include "sdram_defines.svh"

module sdram_frontend #(
    parameter int LATCH = 0
) (
    input  wire logic                                   clk,
    input  wire logic                                   rst,
    input  sdram_cmd_pkg::bank_req_t [`SDRAM_BANKS-1:0] req,
    input  wire logic                                   prog_en,
    input  wire logic                                   prog_rd,
    input  wire logic                                   prog_wr,
    input  wire logic                                   cfg_wr,
    input  wire logic                                   cfg_addr,
    input  wire logic [7:0]                             cfg_wdata,
    output logic [7:0]                                  cfg_rdata,
    output sdram_cmd_pkg::sdram_cmd_t                   cmd,
    output logic [`SDRAM_BANKS-1:0]                     done
);

    sdram_cmd_pkg::bank_req_t [`SDRAM_BANKS-1:0]    req_l;
    logic [`SDRAM_BANKS-1:0][`SDRAM_ROW_W-1:0]      open_row;
    logic [`SDRAM_BANKS-1:0]                        match;
    logic [`SDRAM_BANKS-1:0]                        open;
    logic                                           noreq;
    sdram_cmd_pkg::idle_pre_t                       idle_pre;
    sdram_cfg_pkg::cfg_t                            cfg;

    // client requests and row hits
    sdram_req_latch #(
        .LATCH(LATCH)
    ) u_latch (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .open_row (open_row),
        .prog_en  (prog_en),
        .prog_rd  (prog_rd),
        .prog_wr  (prog_wr),
        .req_l    (req_l),
        .match    (match),
        .noreq    (noreq)
    );

    // open rows, idle close
    sdram_row_track u_track (
        .clk      (clk),
        .rst      (rst),
        .cmd      (cmd),
        .cfg      (cfg),
        .noreq    (noreq),
        .open_row (open_row),
        .open     (open),
        .idle_pre (idle_pre)
    );

    // arbitration and commands
    sdram_bank_sched u_sched (
        .clk      (clk),
        .rst      (rst),
        .req_l    (req_l),
        .match    (match),
        .open     (open),
        .idle_pre (idle_pre),
        .cfg      (cfg),
        .cmd      (cmd),
        .done     (done)
    );

    sdram_bank_cfg u_cfg (
        .clk       (clk),
        .rst       (rst),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .cfg       (cfg)
    );

endmodule

`default_nettype wire

//--- verilog/sdram_req_latch.sv
// SDRAM request latch
// optionally registers the four bank requests, flags row hits
// against the open rows and reports when nothing is requested

`default_nettype none

`include "sdram_defines.svh"

module sdram_req_latch #(
    parameter int LATCH = 0
) (
    input  wire logic                                           clk,
    input  wire logic                                           rst,
    input  sdram_cmd_pkg::bank_req_t [`SDRAM_BANKS-1:0]         req,
    input  wire logic [`SDRAM_BANKS-1:0][`SDRAM_ROW_W-1:0]      open_row,
    input  wire logic                                           prog_en,
    input  wire logic                                           prog_rd,
    input  wire logic                                           prog_wr,
    output sdram_cmd_pkg::bank_req_t [`SDRAM_BANKS-1:0]         req_l,
    output logic [`SDRAM_BANKS-1:0]                             match,
    output logic                                                noreq
);

    logic prog_rq;
    logic noreq_c;

    // programming access also counts as activity
    assign prog_rq = prog_en & (prog_rd | prog_wr);

    always_comb begin
        noreq_c = ~prog_rq;
        for (int b = 0; b < `SDRAM_BANKS; b++) begin
            if (req[b].rd || req[b].wr) begin
                noreq_c = 1'b0;
            end
        end
    end

    generate
        if (LATCH == 1) begin : g_reg
            // one cycle later, idle after reset
            always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                    req_l <= '0;
                    noreq <= 1'b1;
                end else begin
                    req_l <= req;
                    noreq <= noreq_c;
                end
            end
        end else begin : g_pass
            // straight through
            always_comb begin
                req_l = req;
                noreq = noreq_c;
            end
        end
    endgenerate

    // row hit against the row open now, so a fresh ACT is seen at once
    always_comb begin
        for (int b = 0; b < `SDRAM_BANKS; b++) begin
            match[b] = req_l[b].addr[`SDRAM_ROW_LSB +: `SDRAM_ROW_W] == open_row[b];
        end
    end

    // clients never ask for both directions at once
    for (genvar b = 0; b < `SDRAM_BANKS; b++) begin : g_chk
        a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
            !(req[b].rd && req[b].wr));
    end

endmodule

`default_nettype wire

//--- verilog/sdram_row_track.sv
// SDRAM row tracker
// follows ACT, PRE and auto-precharge to keep one open row per bank
// and closes rows after a programmable stretch without requests

`default_nettype none

`include "sdram_defines.svh"

module sdram_row_track (
    input  wire logic                                      clk,
    input  wire logic                                      rst,
    input  sdram_cmd_pkg::sdram_cmd_t                      cmd,
    input  sdram_cfg_pkg::cfg_t                            cfg,
    input  wire logic                                      noreq,
    output logic [`SDRAM_BANKS-1:0][`SDRAM_ROW_W-1:0]      open_row,
    output logic [`SDRAM_BANKS-1:0]                        open,
    output sdram_cmd_pkg::idle_pre_t                       idle_pre
);

    logic [`SDRAM_IDLE_W-1:0] idle_cnt;
    logic                     idle_hit;
    logic                     auto_close;

    // top column bit closes the row with the access
    assign auto_close = cmd.col[`SDRAM_ROW_LSB-1];

    // bank state, changes visible next cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            open     <= '0;
            open_row <= '0;
        end else begin
            case (cmd.code)
                sdram_cmd_pkg::ACT: begin
                    open[cmd.bank]     <= 1'b1;
                    open_row[cmd.bank] <= cmd.row;
                end
                sdram_cmd_pkg::PRE: begin
                    open[cmd.bank] <= 1'b0;
                end
                sdram_cmd_pkg::RD, sdram_cmd_pkg::WR: begin
                    if (auto_close) begin
                        open[cmd.bank] <= 1'b0;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // consecutive quiet cycles, saturates at the limit
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            idle_cnt <= '0;
        end else if (!noreq) begin
            idle_cnt <= '0;
        end else if (idle_cnt < cfg.idle_limit) begin
            idle_cnt <= idle_cnt + 1'b1;
        end
    end

    assign idle_hit = (cfg.idle_limit != '0) && noreq && (idle_cnt >= cfg.idle_limit);

    // lowest open bank first, one per cycle
    always_comb begin
        idle_pre = '0;
        for (int b = `SDRAM_BANKS - 1; b >= 0; b--) begin
            if (open[b]) begin
                idle_pre.bank = 2'(b);
            end
        end
        idle_pre.valid = idle_hit && (|open);
    end

    // scheduler must not reopen or close a bank twice
    a_act_closed: assert property (@(posedge clk) disable iff (rst)
        cmd.code == sdram_cmd_pkg::ACT |-> !open[cmd.bank]);
    a_pre_open: assert property (@(posedge clk) disable iff (rst)
        cmd.code == sdram_cmd_pkg::PRE |-> open[cmd.bank]);

endmodule

`default_nettype wire
